// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

  // line geometry
  localparam int line_bytes = 64;                      // bytes per cache line
  localparam int line_bits = line_bytes * 8;
  localparam int offset_bits = $clog2(line_bytes);     // 6

  // address geometry
  localparam int pc_bits = 64;
  localparam int line_addr_bits = pc_bits - offset_bits;  // 58

  // l0 line buffer, direct mapped
  localparam int l0_entries = 4;
  localparam int index_bits = $clog2(l0_entries);      // 2
  localparam int tag_bits = pc_bits - index_bits - offset_bits;  // 56

  typedef logic [line_bits-1:0] line_t;                // byte 0 sits in bits 7:0
  typedef logic [pc_bits-1:0] pc_t;                    // byte address
  typedef logic [offset_bits-1:0] offset_t;            // byte inside a line
  typedef logic [index_bits-1:0] l0_index_t;           // pc[7:6]
  typedef logic [tag_bits-1:0] l0_tag_t;               // pc[63:8]
  typedef logic [line_addr_bits-1:0] line_addr_t;      // pc without the offset

  // pc split the way the l0 sees it
  typedef struct packed {
    l0_tag_t   tag;
    l0_index_t index;
    offset_t   offset;
  } pc_fields_t;

  // per-entry bookkeeping, the line data lives in its own array
  typedef struct packed {
    logic    valid;
    l0_tag_t tag;
  } l0_meta_t;

endpackage

// ==== rtl/op_pkg.sv ====
package op_pkg;

  localparam int instr_width = 32;                     // fixed width a64 encoding
  localparam int instr_bytes = instr_width / 8;
  localparam int super_scalar_width = 4;               // slots per bundle

  typedef logic [instr_width-1:0] instr_t;
  typedef instr_t [super_scalar_width-1:0] instruction_array;  // slot 0 in low bits

  // 0..4 real slots
  typedef logic [$clog2(super_scalar_width+1)-1:0] slot_count_t;

  // hint #0, i.e. nop
  localparam instr_t nop_instr = 32'hD503201F;

  // one aligned bundle and how much of it is real
  typedef struct packed {
    instruction_array instrs;
    slot_count_t      count;
  } bundle_t;

endpackage

// ==== rtl/align_instructions.sv ====
`timescale 1ns/10ps

module align_instructions
  import fetch_pkg::*;
  import op_pkg::*;
(
  input  offset_t          offset,      // byte offset of the fetch pc
  input  line_t            cacheline,
  output instruction_array instr_out,
  output slot_count_t      slot_count   // slots that hold real words
);

  // one extra bit so offset + 4*i never wraps
  typedef logic [offset_bits:0] start_t;

  logic [super_scalar_width-1:0] slot_real;

  for (genvar i = 0; i < super_scalar_width; i++) begin : g_slot
    start_t start;
    line_t  shifted;

    assign start = {1'b0, offset} + start_t'(i * instr_bytes);
    // bring the first byte of this slot down to bit 0, little endian as stored
    assign shifted = cacheline >> {start[offset_bits-1:0], 3'b000};
    assign slot_real[i] = (start + start_t'(instr_bytes)) <= start_t'(line_bytes);
    assign instr_out[i] = slot_real[i] ? shifted[instr_width-1:0] : nop_instr;  // pad past end
  end

  // real slots form a prefix, so a plain popcount gives the advance
  always_comb begin
    slot_count = '0;
    for (int i = 0; i < super_scalar_width; i++) begin
      slot_count = slot_count + slot_count_t'(slot_real[i]);
    end
  end

endmodule

// ==== rtl/pc_gen.sv ====
`timescale 1ns/10ps

module pc_gen
  import fetch_pkg::*;
  import op_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_N_in,      // sync reset, active high
  input  logic        flush_in,      // mispredict, take redirect_pc
  input  pc_t         redirect_pc,
  input  logic        fetch_ready,   // decode took the bundle for fetch_pc
  input  slot_count_t slot_count,    // real slots of that bundle
  output pc_t         fetch_pc,
  output logic        pc_valid
);

  pc_t advance;

  // 4 bytes per real slot, lands on pc+16 or on the next line start
  assign advance = pc_t'(slot_count) * pc_t'(instr_bytes);

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      fetch_pc <= '0;
      pc_valid <= 1'b0;               // low for the first cycle out of reset
    end else begin
      pc_valid <= 1'b1;
      if (flush_in) begin
        fetch_pc <= redirect_pc;      // redirect wins over a sequential step
      end else if (fetch_ready) begin
        fetch_pc <= fetch_pc + advance;
      end
    end
  end

endmodule

// ==== rtl/l0_line_buffer.sv ====
`timescale 1ns/10ps

module l0_line_buffer
  import fetch_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_N_in,      // sync reset, active high
  input  logic       flush_in,
  input  pc_t        fetch_pc,
  input  logic       pc_valid,
  input  logic       l1i_valid,     // one cycle response pulse
  input  line_t      l1i_line,
  output line_t      l0_line,
  output logic       l0_hit,
  output logic       l1i_req,       // one cycle request pulse
  output line_addr_t l1i_addr
);

  pc_fields_t pc_f;
  l0_meta_t   meta [l0_entries];    // valid + tag per entry
  line_t      lines [l0_entries];   // line data
  line_addr_t miss_addr;            // line we asked l1i for
  logic       miss_pending;         // request out for the current pc
  logic       late_pending;         // request out from before a flush
  logic       fill_en;
  l0_index_t  fill_index;
  l0_tag_t    fill_tag;

  assign pc_f = fetch_pc;

  // lookup is purely combinational on fetch_pc
  assign l0_line = lines[pc_f.index];
  assign l0_hit = meta[pc_f.index].valid && (meta[pc_f.index].tag == pc_f.tag);

  // a late line still has to land at miss_addr, so hold new requests until it does
  assign l1i_req = pc_valid && !l0_hit && !miss_pending && !late_pending && !flush_in;
  assign l1i_addr = {pc_f.tag, pc_f.index};

  // responses come back in order, the oldest one always belongs to miss_addr
  assign fill_en = l1i_valid && (miss_pending || late_pending);
  assign fill_index = miss_addr[index_bits-1:0];
  assign fill_tag = miss_addr[line_addr_bits-1:index_bits];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      miss_pending <= 1'b0;
      late_pending <= 1'b0;
      for (int i = 0; i < l0_entries; i++) begin
        meta[i].valid <= 1'b0;
      end
    end else begin
      if (fill_en) begin
        meta[fill_index] <= '{valid: 1'b1, tag: fill_tag};  // hit from next cycle on
      end
      if (l1i_valid) begin
        miss_pending <= 1'b0;
        late_pending <= 1'b0;
      end else if (flush_in) begin
        // outstanding line is now stale for fetch but still good data here
        late_pending <= late_pending | miss_pending;
        miss_pending <= 1'b0;
      end else if (l1i_req) begin
        miss_pending <= 1'b1;
      end
    end
  end

  // data side
  always_ff @(posedge clk_in) begin
    if (fill_en) begin
      lines[fill_index] <= l1i_line;
    end
    if (l1i_req) begin
      miss_addr <= l1i_addr;  // remembered for the fill
    end
  end

endmodule

// ==== rtl/fetch.sv ====
`timescale 1ns/10ps

module fetch
  import fetch_pkg::*;
  import op_pkg::*;
(
  input  logic             clk_in,
  input  logic             rst_N_in,        // sync reset, active high
  input  logic             flush_in,        // mispredict flush
  input  line_t            l0_cacheline,    // line from the l0 buffer
  input  line_t            l1i_cacheline,   // line straight from l1i
  input  logic             bp_l0_valid,     // l0 hit for pred_pc
  input  logic             l1i_valid,
  input  logic             pc_valid,
  input  pc_t              pred_pc,
  input  logic             decode_ready,
  output instruction_array fetched_instrs,  // to decode
  output slot_count_t      slot_count,      // real slots in fetched_instrs
  output logic             fetch_valid,
  output logic             fetch_ready,     // bundle taken, pc may advance
  output pc_t              next_pc          // pc of the registered bundle
);

  pc_fields_t       pc_f;
  instruction_array l0_instrs;
  instruction_array l1i_instrs;
  slot_count_t      l0_count;
  slot_count_t      l1i_count;
  bundle_t          l0_bundle;
  bundle_t          l1i_bundle;
  bundle_t          bundle_next;
  logic             l1i_waiting;           // current pc missed, line on its way
  logic             discard_l1i;           // next response predates a flush
  logic             resp_ok;
  logic             l0_ok;
  logic             load;

  assign pc_f = pred_pc;

  align_instructions l0_align (
    .offset    (pc_f.offset),
    .cacheline (l0_cacheline),
    .instr_out (l0_instrs),
    .slot_count(l0_count)
  );

  align_instructions l1i_align (
    .offset    (pc_f.offset),
    .cacheline (l1i_cacheline),
    .instr_out (l1i_instrs),
    .slot_count(l1i_count)
  );

  assign l0_bundle = '{instrs: l0_instrs, count: l0_count};
  assign l1i_bundle = '{instrs: l1i_instrs, count: l1i_count};

  assign resp_ok = l1i_valid && l1i_waiting && !discard_l1i;  // response for pred_pc
  assign l0_ok = bp_l0_valid && pc_valid;
  assign bundle_next = resp_ok ? l1i_bundle : l0_bundle;     // l1i first

  // a held bundle means pred_pc is already used, wait for the pc step
  assign load = !fetch_valid && (resp_ok || l0_ok);
  assign fetch_ready = fetch_valid && decode_ready;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      fetch_valid <= 1'b0;
      l1i_waiting <= 1'b0;
      discard_l1i <= 1'b0;
    end else if (flush_in) begin
      fetch_valid <= 1'b0;                // drop the bundle even under a stall
      l1i_waiting <= 1'b0;
      // anything still out belongs to the old path
      discard_l1i <= (l1i_waiting && !resp_ok) || (discard_l1i && !l1i_valid);
    end else begin
      if (decode_ready) begin
        fetch_valid <= load;
      end
      discard_l1i <= discard_l1i && !l1i_valid;  // stale line eaten
      // miss tracking runs through stalls so no response is lost
      if (resp_ok || l0_ok) begin
        l1i_waiting <= 1'b0;
      end else if (pc_valid) begin
        l1i_waiting <= 1'b1;                      // no hit, l0 has asked l1i
      end
    end
  end

  // payload held while decode is stalled
  always_ff @(posedge clk_in) begin
    if (decode_ready && load && !flush_in) begin
      fetched_instrs <= bundle_next.instrs;
      slot_count <= bundle_next.count;
      next_pc <= pred_pc;
    end
  end

endmodule

// ==== rtl/frontend_top.sv ====
`timescale 1ns/10ps

module frontend_top
  import fetch_pkg::*;
  import op_pkg::*;
(
  input  logic             clk_in,
  input  logic             rst_N_in,        // sync reset, active high
  input  logic             flush_in,
  input  pc_t              redirect_pc,
  input  logic             decode_ready,
  input  line_t            l1i_line,
  input  logic             l1i_valid,
  output logic             l1i_req,
  output line_addr_t       l1i_addr,
  output instruction_array fetched_instrs,
  output logic             fetch_valid,
  output pc_t              next_pc
);

  pc_t         fetch_pc;
  logic        pc_valid;
  line_t       l0_line;
  logic        l0_hit;
  logic        fetch_ready;   // fetch -> pc_gen step
  slot_count_t slot_count;    // step size in words

  pc_gen pc_gen_i (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .flush_in   (flush_in),
    .redirect_pc(redirect_pc),
    .fetch_ready(fetch_ready),
    .slot_count (slot_count),
    .fetch_pc   (fetch_pc),
    .pc_valid   (pc_valid)
  );

  l0_line_buffer l0_line_buffer_i (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .flush_in (flush_in),
    .fetch_pc (fetch_pc),
    .pc_valid (pc_valid),
    .l1i_valid(l1i_valid),
    .l1i_line (l1i_line),
    .l0_line  (l0_line),
    .l0_hit   (l0_hit),
    .l1i_req  (l1i_req),
    .l1i_addr (l1i_addr)
  );

  // l1i response goes to the buffer fill and to fetch in the same cycle
  fetch fetch_i (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .flush_in      (flush_in),
    .l0_cacheline  (l0_line),
    .l1i_cacheline (l1i_line),
    .bp_l0_valid   (l0_hit),
    .l1i_valid     (l1i_valid),
    .pc_valid      (pc_valid),
    .pred_pc       (fetch_pc),
    .decode_ready  (decode_ready),
    .fetched_instrs(fetched_instrs),
    .slot_count    (slot_count),
    .fetch_valid   (fetch_valid),
    .fetch_ready   (fetch_ready),
    .next_pc       (next_pc)
  );

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen (
  output logic clk_in,
  output logic rst_N_in     // active high, held for three cycles
);

  localparam time half_period = 50;  // 100 ns period

  initial begin
    clk_in = 1'b0;
    forever #half_period clk_in = ~clk_in;
  end

  initial begin
    rst_N_in = 1'b1;
    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    rst_N_in = 1'b0;                 // released away from the active edge
  end

endmodule

// ==== testbench/frontend_properties.sv ====
`timescale 1ns/10ps

module frontend_properties (
  input logic clk_in,
  input logic rst_N_in,
  input logic flush_in,
  input logic fetch_valid,
  input logic l1i_req,
  input logic l1i_valid
);

  logic outstanding;  // request sent, no response yet

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      outstanding <= 1'b0;
    end else if (l1i_valid) begin
      outstanding <= 1'b0;
    end else if (l1i_req) begin
      outstanding <= 1'b1;
    end
  end

  // flushed bundle never reaches decode
  assert property (@(posedge clk_in) disable iff (rst_N_in) flush_in |=> !fetch_valid)
    else $error("fetch_valid high in the cycle after a flush");

  assert property (@(posedge clk_in) disable iff (rst_N_in) l1i_req |=> !l1i_req)
    else $error("l1i_req held longer than one cycle");

  // also covers a stale line still out after a flush
  assert property (@(posedge clk_in) disable iff (rst_N_in) l1i_req |-> !outstanding)
    else $error("second l1i request while one is outstanding");

endmodule

// ==== testbench/tb_frontend.sv ====
`timescale 1ns/10ps

module tb_frontend
  import fetch_pkg::*;
  import op_pkg::*;
();

  localparam int num_tests = 6;

  logic             clk_in, rst_N_in;
  logic             flush_in, decode_ready, l1i_valid, l1i_req, fetch_valid;
  pc_t              redirect_pc, next_pc, exp_pc;
  line_t            l1i_line;
  line_addr_t       l1i_addr;
  instruction_array fetched_instrs, held_instrs;
  pc_t              held_pc;
  int               errors = 0;
  int               accepted = 0;
  int               req_count = 0;
  string            test_name;

  clock_gen clock_gen_i (.clk_in(clk_in), .rst_N_in(rst_N_in));

  frontend_top frontend_top_i (.*);

  bind frontend_top frontend_properties props_i (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .flush_in(flush_in),
    .fetch_valid(fetch_valid), .l1i_req(l1i_req), .l1i_valid(l1i_valid)
  );

  // pattern word for a byte address
  function automatic instr_t word_at(input pc_t a);
    return instr_t'(a >> 2) ^ 32'h5A5A0000;
  endfunction

  function automatic line_t line_for(input line_addr_t la);
    line_t l;
    l = '0;
    for (int w = 0; w < 16; w++) begin
      l[w*32 +: 32] = word_at({la, 6'b0} + pc_t'(4 * w));
    end
    return l;
  endfunction

  // words from pc with nop past the line end
  function automatic instruction_array bundle_for(input pc_t pc);
    instruction_array b;
    for (int i = 0; i < 4; i++) begin
      b[i] = (int'(pc[5:0]) + 4 * i + 4 <= 64) ? word_at(pc + pc_t'(4 * i)) : nop_instr;
    end
    return b;
  endfunction

  function automatic pc_t step_pc(input pc_t pc);
    return (int'(pc[5:0]) + 16 <= 64) ? pc + 16 : {pc[63:6] + 58'd1, 6'b0};
  endfunction

  task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // l1i model answers one request at a time after 2 to 8 cycles
  initial begin
    line_addr_t a;
    int unsigned delay;
    l1i_valid = 1'b0;
    l1i_line = '0;
    forever begin
      @(posedge clk_in);
      if (l1i_req && !rst_N_in) begin
        a = l1i_addr;
        check("l1i_addr", 128'(exp_pc[63:6]), 128'(a));  // line of the pc being fetched
        delay = 2 + $urandom % 7;
        repeat (delay) @(negedge clk_in);
        l1i_line = line_for(a);
        l1i_valid = 1'b1;
        @(negedge clk_in);
        l1i_valid = 1'b0;
      end
    end
  end

  always @(posedge clk_in) begin
    if (l1i_req && !rst_N_in) req_count++;
  end

  // drive one cycle and check the bundle taken at the coming edge
  task automatic cycle(input logic ready, input logic flush, input pc_t target);
    @(negedge clk_in);
    decode_ready = ready;
    flush_in = flush;
    redirect_pc = target;
    if (fetch_valid && decode_ready) begin
      check("pc", 128'(exp_pc), 128'(next_pc));
      check("instrs", bundle_for(exp_pc), fetched_instrs);
      exp_pc = step_pc(exp_pc);
      accepted++;
    end
    if (flush) exp_pc = target;
  endtask

  task automatic run_bundles(input int n, input bit random_ready);
    int goal;
    goal = accepted + n;
    while (accepted < goal) cycle(random_ready ? ($urandom % 4 != 0) : 1'b1, 1'b0, '0);
  endtask

  task automatic finish_test();
    $display("test %s done, errors so far %0d", test_name, errors);
  endtask

  task automatic cold_sequential();
    test_name = "cold_sequential";
    run_bundles(12, 0);                     // three lines from pc 0
    finish_test();
  endtask

  task automatic line_end_nop();
    test_name = "line_end_nop";
    cycle(1'b1, 1'b1, 64'h1038);             // offset 56 gives two words then nops
    run_bundles(3, 0);
    finish_test();
  endtask

  task automatic back_pressure();
    test_name = "back_pressure";
    cycle(1'b1, 1'b1, 64'h3000);
    run_bundles(4, 0);                      // pc now at the next line, a miss
    cycle(1'b0, 1'b0, '0);
    held_instrs = fetched_instrs;
    held_pc = next_pc;
    repeat (12) begin                       // next line arrives while stalled
      cycle(1'b0, 1'b0, '0);
      check("held instrs", held_instrs, fetched_instrs);
      check("held pc", 128'(held_pc), 128'(next_pc));
    end
    run_bundles(8, 0);
    finish_test();
  endtask

  task automatic flush_miss();
    int start;
    test_name = "flush_miss";
    start = req_count;
    while (req_count == start) cycle(1'b1, 1'b0, '0);
    cycle(1'b1, 1'b1, 64'h8010);             // stale line still on its way
    run_bundles(4, 0);
    finish_test();
  endtask

  task automatic l0_reuse();
    int start;
    test_name = "l0_reuse";
    cycle(1'b1, 1'b1, 64'h2000);
    run_bundles(8, 0);
    cycle(1'b1, 1'b1, 64'h2000);             // both lines now resident
    start = req_count;
    run_bundles(8, 0);
    check("l1i requests", 128'(start), 128'(req_count));
    finish_test();
  endtask

  task automatic random_redirects();
    test_name = "random_redirects";
    repeat (40) begin
      cycle(1'b1, 1'b1, pc_t'($urandom & 32'h3ffc));
      run_bundles(1 + $urandom % 6, 1);
    end
    finish_test();
  endtask

  initial begin
    void'($urandom(32'hba3f));
    decode_ready = 1'b1;
    flush_in = 1'b0;
    redirect_pc = '0;
    exp_pc = '0;
    test_name = "reset";
    wait (rst_N_in === 1'b0);
    cold_sequential();
    line_end_nop();
    back_pressure();
    flush_miss();
    l0_reuse();
    random_redirects();
    $display("tests %0d, bundles %0d, errors %0d", num_tests, accepted, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog allows 2000 cycles per test
  initial begin
    #(num_tests * 2000 * 100);
    $display("timeout: the tests did not finish in time, stuck in %s", test_name);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/fetch_pkg.sv
rtl/op_pkg.sv
rtl/align_instructions.sv
rtl/pc_gen.sv
rtl/l0_line_buffer.sv
rtl/fetch.sv
rtl/frontend_top.sv
testbench/clock_gen.sv
testbench/frontend_properties.sv
testbench/tb_frontend.sv

// ==== Makefile ====
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend -f list.f -Mdir obj_dir
	./obj_dir/Vtb_frontend | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
